/* rtl/afu_cfg_pkg.sv */
// control side definitions shared by the host register file and the run sequencer
package afu_cfg_pkg;

	// host register bus
	typedef logic [7:0]  ctrl_addr_t;
	typedef logic [31:0] ctrl_data_t;

	// device configuration writes forwarded to the core
	typedef logic [11:0] dcr_addr_t;
	typedef logic [31:0] dcr_data_t;

	// register map
	localparam ctrl_addr_t REG_CTRL     = 8'h00;
	localparam ctrl_addr_t REG_GIE      = 8'h04;
	localparam ctrl_addr_t REG_IER      = 8'h08;
	localparam ctrl_addr_t REG_ISR      = 8'h0C;
	localparam ctrl_addr_t REG_DCR_ADDR = 8'h10;
	localparam ctrl_addr_t REG_DCR_DATA = 8'h14;

	// bit positions in the control word
	localparam int CTRL_START_BIT      = 0;
	localparam int CTRL_DONE_BIT       = 1;
	localparam int CTRL_IDLE_BIT       = 2;
	localparam int CTRL_READY_BIT      = 3;
	localparam int CTRL_SOFT_RESET_BIT = 4;

	typedef enum logic [1:0] {
		run_idle,
		run_init,
		run_busy,
		run_done
	} run_state_e;

	localparam int RESET_DELAY_DEFAULT = 16;

endpackage

/* rtl/afu_mem_pkg.sv */
// memory side definitions for address relocation and write drain tracking
package afu_mem_pkg;

	// address as the platform memory sees it
	typedef logic [63:0] mem_addr_t;

	// address as the core issues it
	typedef logic [31:0] core_addr_t;

	localparam int NUM_BANKS_DEFAULT = 2;

	// platform base of the device memory window
	localparam mem_addr_t MEM_OFFSET_DEFAULT = 64'h44A0_0000;

	// outstanding write count sized for the deepest write queue of the core
	typedef logic [11:0] pending_t;

endpackage

/* rtl/kernel_ctrl_if.sv */
// kernel control handshake between the host register file and the run sequencer
`timescale 1ns/1ps

interface kernel_ctrl_if;

	// strobes from the register side
	logic start;
	logic soft_reset;
	logic done_ack;

	// levels from the sequencer
	logic done;
	logic idle;

	modport regs (
		output start,
		output soft_reset,
		output done_ack,
		input  done,
		input  idle
	);

	modport fsm (
		input  start,
		input  soft_reset,
		input  done_ack,
		output done,
		output idle
	);

endinterface

/* rtl/host_ctrl_regs.sv */
// host register file in afu_top for control strobes, interrupt enables, status and DCR forwarding
`timescale 1ns/1ps

module host_ctrl_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   reg_wr,
	input  logic                   reg_rd,
	input  afu_cfg_pkg::ctrl_addr_t reg_addr,
	input  afu_cfg_pkg::ctrl_data_t reg_wdata,
	output logic                   reg_rvalid,
	output afu_cfg_pkg::ctrl_data_t reg_rdata,
	output logic                   interrupt,
	output logic                   dcr_wr_valid,
	output afu_cfg_pkg::dcr_addr_t  dcr_wr_addr,
	output afu_cfg_pkg::dcr_data_t  dcr_wr_data,
	kernel_ctrl_if.regs            ctrl
);
	import afu_cfg_pkg::*;

	logic       wr_ctrl;
	logic       wr_isr;
	logic       wr_dcr_data;
	logic       start_q;
	logic       soft_reset_q;
	logic       gie;
	logic       ier;
	logic       isr_done;
	logic       done_q;
	dcr_addr_t  dcr_addr_q;
	ctrl_data_t status;
	ctrl_data_t rd_mux;

	assign wr_ctrl     = reg_wr && (reg_addr == REG_CTRL);
	assign wr_isr      = reg_wr && (reg_addr == REG_ISR);
	assign wr_dcr_data = reg_wr && (reg_addr == REG_DCR_DATA);

	assign ctrl.start      = start_q;
	assign ctrl.soft_reset = soft_reset_q;
	// reading the control word acknowledges done in the same cycle it is sampled
	assign ctrl.done_ack   = reg_rd && (reg_addr == REG_CTRL);

	assign interrupt = gie & ier & isr_done;

	always_comb begin
		status = '0;
		status[CTRL_START_BIT] = ~ctrl.idle & ~ctrl.done;
		status[CTRL_DONE_BIT]  = ctrl.done;
		status[CTRL_IDLE_BIT]  = ctrl.idle;
		status[CTRL_READY_BIT] = ctrl.done;
	end

	always_comb begin
		case (reg_addr)
			REG_CTRL:     rd_mux = status;
			REG_GIE:      rd_mux = ctrl_data_t'(gie);
			REG_IER:      rd_mux = ctrl_data_t'(ier);
			REG_ISR:      rd_mux = ctrl_data_t'(isr_done);
			REG_DCR_ADDR: rd_mux = ctrl_data_t'(dcr_addr_q);
			REG_DCR_DATA: rd_mux = ctrl_data_t'(dcr_wr_data);
			default:      rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start_q      <= 1'b0;
			soft_reset_q <= 1'b0;
			gie          <= 1'b0;
			ier          <= 1'b0;
			isr_done     <= 1'b0;
			done_q       <= 1'b0;
			dcr_addr_q   <= '0;
			dcr_wr_valid <= 1'b0;
			reg_rvalid   <= 1'b0;
		end else begin
			start_q      <= wr_ctrl && reg_wdata[CTRL_START_BIT];
			soft_reset_q <= wr_ctrl && reg_wdata[CTRL_SOFT_RESET_BIT];
			dcr_wr_valid <= wr_dcr_data;
			reg_rvalid   <= reg_rd;
			done_q       <= ctrl.done;
			if (reg_wr && (reg_addr == REG_GIE)) begin
				gie <= reg_wdata[0];
			end
			if (reg_wr && (reg_addr == REG_IER)) begin
				ier <= reg_wdata[0];
			end
			if (reg_wr && (reg_addr == REG_DCR_ADDR)) begin
				dcr_addr_q <= dcr_addr_t'(reg_wdata);
			end
			// a new done edge wins over a clear in the same cycle
			if (ctrl.done && !done_q) begin
				isr_done <= 1'b1;
			end else if (wr_isr && reg_wdata[0]) begin
				isr_done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_rd) begin
			reg_rdata <= rd_mux;
		end
		if (wr_dcr_data) begin
			dcr_wr_addr <= dcr_addr_q;
			dcr_wr_data <= reg_wdata;
		end
	end

endmodule

/* rtl/kernel_run_fsm.sv */
// kernel run sequencer in afu_top that holds the core in reset and reports done once writes drain
`timescale 1ns/1ps

module kernel_run_fsm #(
	parameter int RESET_DELAY = afu_cfg_pkg::RESET_DELAY_DEFAULT
) (
	input  logic                 clk,
	input  logic                 reset,
	kernel_ctrl_if.fsm           ctrl,
	input  logic                 core_busy,
	input  afu_mem_pkg::pending_t pending,
	output logic                 core_reset
);
	import afu_cfg_pkg::*;

	localparam int CTR_W = $clog2(RESET_DELAY + 1);

	run_state_e       state;
	logic [CTR_W-1:0] reset_ctr;

	assign ctrl.idle = (state == run_idle);
	// done waits for every accepted write to be acknowledged
	assign ctrl.done = (state == run_done) && (pending == '0);

	always_ff @(posedge clk) begin
		if (reset || ctrl.soft_reset) begin
			state      <= run_idle;
			core_reset <= 1'b1;
			reset_ctr  <= '0;
		end else begin
			case (state)
				run_idle: begin
					if (ctrl.start) begin
						state      <= run_init;
						core_reset <= 1'b1;
						reset_ctr  <= CTR_W'(RESET_DELAY - 1);
					end
				end
				run_init: begin
					if (core_reset) begin
						// release after RESET_DELAY cycles from the start strobe
						if (reset_ctr == '0) begin
							core_reset <= 1'b0;
						end else begin
							reset_ctr <= reset_ctr - 1'b1;
						end
					end else if (core_busy) begin
						state <= run_busy;
					end
				end
				run_busy: begin
					if (!core_busy) begin
						state <= run_done;
					end
				end
				run_done: begin
					if (ctrl.done && ctrl.done_ack) begin
						state <= run_idle;
					end
				end
				default: begin
					state <= run_idle;
				end
			endcase
		end
	end

endmodule

/* rtl/mem_bank_port.sv */
// per-bank port in afu_top that relocates core addresses and reports accepted and acked writes
`timescale 1ns/1ps

module mem_bank_port #(
	parameter afu_mem_pkg::mem_addr_t MEM_OFFSET = afu_mem_pkg::MEM_OFFSET_DEFAULT
) (
	input  logic                   clk,
	input  logic                   reset,
	input  afu_mem_pkg::core_addr_t core_aw_addr,
	input  afu_mem_pkg::core_addr_t core_ar_addr,
	output afu_mem_pkg::mem_addr_t  mem_aw_addr,
	output afu_mem_pkg::mem_addr_t  mem_ar_addr,
	input  logic                   aw_valid,
	input  logic                   aw_ready,
	input  logic                   w_valid,
	input  logic                   w_ready,
	input  logic                   b_valid,
	input  logic                   b_ready,
	output logic                   wr_req_fire,
	output logic                   wr_rsp_fire
);
	import afu_mem_pkg::*;

	logic aw_fire;
	logic w_fire;
	logic aw_seen;
	logic w_seen;

	// zero-extend then add with wrap at 64 bits
	assign mem_aw_addr = mem_addr_t'(core_aw_addr) + MEM_OFFSET;
	assign mem_ar_addr = mem_addr_t'(core_ar_addr) + MEM_OFFSET;

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire  = w_valid && w_ready;

	// a write is accepted once both its address and its data have been taken
	assign wr_req_fire = (aw_fire || aw_seen) && (w_fire || w_seen);
	assign wr_rsp_fire = b_valid && b_ready;

	// one handshake of lead per channel is remembered
	always_ff @(posedge clk) begin
		if (reset) begin
			aw_seen <= 1'b0;
			w_seen  <= 1'b0;
		end else begin
			aw_seen <= (aw_seen && aw_fire) || ((aw_seen || aw_fire) && !wr_req_fire);
			w_seen  <= (w_seen && w_fire) || ((w_seen || w_fire) && !wr_req_fire);
		end
	end

endmodule

/* rtl/write_drain_counter.sv */
// counts writes accepted but not yet acknowledged over all memory banks
`timescale 1ns/1ps

module write_drain_counter #(
	parameter int NUM_BANKS = afu_mem_pkg::NUM_BANKS_DEFAULT
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_BANKS-1:0] wr_req_fire,
	input  logic [NUM_BANKS-1:0] wr_rsp_fire,
	output afu_mem_pkg::pending_t pending
);
	import afu_mem_pkg::*;

	localparam int CNT_W = $clog2(NUM_BANKS + 1);

	logic [CNT_W-1:0]        req_cnt;
	logic [CNT_W-1:0]        rsp_cnt;
	logic signed [CNT_W:0]   delta;

	always_comb begin
		req_cnt = '0;
		rsp_cnt = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			req_cnt = req_cnt + CNT_W'(wr_req_fire[i]);
			rsp_cnt = rsp_cnt + CNT_W'(wr_rsp_fire[i]);
		end
	end

	assign delta = $signed({1'b0, req_cnt}) - $signed({1'b0, rsp_cnt});

	// the cast sign-extends the difference before it is added
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= pending + pending_t'(delta);
		end
	end

endmodule

/* rtl/afu_top.sv */
// top level of the accelerator host wrapper that ties registers, sequencer and banks to plain ports
`timescale 1ns/1ps

module afu_top #(
	parameter int                     NUM_BANKS   = afu_mem_pkg::NUM_BANKS_DEFAULT,
	parameter int                     RESET_DELAY = afu_cfg_pkg::RESET_DELAY_DEFAULT,
	parameter afu_mem_pkg::mem_addr_t MEM_OFFSET  = afu_mem_pkg::MEM_OFFSET_DEFAULT
) (
	input  logic                                    clk,
	input  logic                                    reset,

	// host register strobes
	input  logic                                    reg_wr,
	input  logic                                    reg_rd,
	input  afu_cfg_pkg::ctrl_addr_t                 reg_addr,
	input  afu_cfg_pkg::ctrl_data_t                 reg_wdata,
	output logic                                    reg_rvalid,
	output afu_cfg_pkg::ctrl_data_t                 reg_rdata,
	output logic                                    interrupt,

	// core side
	input  logic                                    core_busy,
	output logic                                    core_reset,
	output logic                                    dcr_wr_valid,
	output afu_cfg_pkg::dcr_addr_t                  dcr_wr_addr,
	output afu_cfg_pkg::dcr_data_t                  dcr_wr_data,
	input  afu_mem_pkg::core_addr_t [NUM_BANKS-1:0] core_aw_addr,
	input  afu_mem_pkg::core_addr_t [NUM_BANKS-1:0] core_ar_addr,

	// memory channels, observed only
	output afu_mem_pkg::mem_addr_t  [NUM_BANKS-1:0] mem_aw_addr,
	output afu_mem_pkg::mem_addr_t  [NUM_BANKS-1:0] mem_ar_addr,
	input  logic                    [NUM_BANKS-1:0] aw_valid,
	input  logic                    [NUM_BANKS-1:0] aw_ready,
	input  logic                    [NUM_BANKS-1:0] w_valid,
	input  logic                    [NUM_BANKS-1:0] w_ready,
	input  logic                    [NUM_BANKS-1:0] b_valid,
	input  logic                    [NUM_BANKS-1:0] b_ready
);
	import afu_mem_pkg::*;

	logic [NUM_BANKS-1:0] wr_req_fire;
	logic [NUM_BANKS-1:0] wr_rsp_fire;
	pending_t             pending;

	kernel_ctrl_if ctrl_if ();

	host_ctrl_regs regs_i (
		.clk          (clk),
		.reset        (reset),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rvalid   (reg_rvalid),
		.reg_rdata    (reg_rdata),
		.interrupt    (interrupt),
		.dcr_wr_valid (dcr_wr_valid),
		.dcr_wr_addr  (dcr_wr_addr),
		.dcr_wr_data  (dcr_wr_data),
		.ctrl         (ctrl_if.regs)
	);

	kernel_run_fsm #(
		.RESET_DELAY (RESET_DELAY)
	) fsm_i (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl_if.fsm),
		.core_busy  (core_busy),
		.pending    (pending),
		.core_reset (core_reset)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		mem_bank_port #(
			.MEM_OFFSET (MEM_OFFSET)
		) bank_i (
			.clk          (clk),
			.reset        (reset),
			.core_aw_addr (core_aw_addr[i]),
			.core_ar_addr (core_ar_addr[i]),
			.mem_aw_addr  (mem_aw_addr[i]),
			.mem_ar_addr  (mem_ar_addr[i]),
			.aw_valid     (aw_valid[i]),
			.aw_ready     (aw_ready[i]),
			.w_valid      (w_valid[i]),
			.w_ready      (w_ready[i]),
			.b_valid      (b_valid[i]),
			.b_ready      (b_ready[i]),
			.wr_req_fire  (wr_req_fire[i]),
			.wr_rsp_fire  (wr_rsp_fire[i])
		);
	end

	write_drain_counter #(
		.NUM_BANKS (NUM_BANKS)
	) drain_i (
		.clk         (clk),
		.reset       (reset),
		.wr_req_fire (wr_req_fire),
		.wr_rsp_fire (wr_rsp_fire),
		.pending     (pending)
	);

endmodule

/* tests/afu_tb.sv */
// testbench for the accelerator host wrapper; models host, core and memory and checks the DUT
`timescale 1ns/1ps

module afu_tb;
	import afu_cfg_pkg::*;
	import afu_mem_pkg::*;

	localparam int        NUM_BANKS    = 2;
	localparam int        RESET_DELAY  = 16;
	localparam mem_addr_t MEM_OFFSET   = 64'h44A0_0000;
	localparam int        CLK_PERIOD   = 100;
	localparam int        DCR_WRITES   = 8;
	localparam int        ADDR_SAMPLES = 32;
	localparam int        BANK_WRITES  = 5;
	localparam int        POLL_LIMIT   = 200;
	// cycles for one kernel run with reset hold, busy time, bank traffic and done polling
	localparam int RUN_CYCLES   = RESET_DELAY + 40 + BANK_WRITES * NUM_BANKS * 12 + POLL_LIMIT;
	localparam int TOTAL_CYCLES = 10 + DCR_WRITES * 4 + 3 * RUN_CYCLES + ADDR_SAMPLES + 200;

	logic                       clk;
	logic                       reset;
	logic                       reg_wr;
	logic                       reg_rd;
	ctrl_addr_t                 reg_addr;
	ctrl_data_t                 reg_wdata;
	logic                       reg_rvalid;
	ctrl_data_t                 reg_rdata;
	logic                       interrupt;
	logic                       core_busy;
	logic                       core_reset;
	logic                       dcr_wr_valid;
	dcr_addr_t                  dcr_wr_addr;
	dcr_data_t                  dcr_wr_data;
	core_addr_t [NUM_BANKS-1:0] core_aw_addr;
	core_addr_t [NUM_BANKS-1:0] core_ar_addr;
	mem_addr_t  [NUM_BANKS-1:0] mem_aw_addr;
	mem_addr_t  [NUM_BANKS-1:0] mem_ar_addr;
	logic       [NUM_BANKS-1:0] aw_valid;
	logic       [NUM_BANKS-1:0] aw_ready;
	logic       [NUM_BANKS-1:0] w_valid;
	logic       [NUM_BANKS-1:0] w_ready;
	logic       [NUM_BANKS-1:0] b_valid;
	logic       [NUM_BANKS-1:0] b_ready;

	logic [31:0] lfsr;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          accepted;
	int          acked;
	int          acks_left [NUM_BANKS];

	afu_top #(
		.NUM_BANKS   (NUM_BANKS),
		.RESET_DELAY (RESET_DELAY),
		.MEM_OFFSET  (MEM_OFFSET)
	) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", TOTAL_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic mem_addr_t relocated(input core_addr_t a);
		return mem_addr_t'(a) + MEM_OFFSET;
	endfunction

	function automatic ctrl_data_t status_word(input logic idle, input logic done);
		ctrl_data_t w;
		w = '0;
		w[CTRL_START_BIT] = !idle && !done;
		w[CTRL_DONE_BIT]  = done;
		w[CTRL_IDLE_BIT]  = idle;
		w[CTRL_READY_BIT] = done;
		return w;
	endfunction

	function automatic int outstanding_writes(input int acc, input int ack);
		return acc - ack;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - start_errors);
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic reg_write(input ctrl_addr_t addr, input ctrl_data_t data);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		step_cycle();
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input ctrl_addr_t addr, output ctrl_data_t data);
		reg_rd = 1'b1;
		reg_addr = addr;
		step_cycle();
		reg_rd = 1'b0;
		if (reg_rvalid !== 1'b1)
			report_failure("reg_rvalid did not follow a read by one cycle");
		data = reg_rdata;
	endtask

	task automatic wait_core_release(output int cycles);
		cycles = 0;
		while (core_reset && cycles < 4 * RESET_DELAY) begin
			step_cycle();
			cycles++;
		end
		if (core_reset)
			report_failure("core_reset was never released after start");
	endtask

	// polls the control word; a done read also acknowledges done
	task automatic wait_done(output ctrl_data_t word);
		int polls;
		polls = 0;
		word = '0;
		while (!word[CTRL_DONE_BIT] && polls < POLL_LIMIT) begin
			reg_read(REG_CTRL, word);
			polls++;
			if (word[CTRL_DONE_BIT] && outstanding_writes(accepted, acked) != 0)
				report_failure("done reported while writes were still outstanding");
		end
		if (!word[CTRL_DONE_BIT])
			report_failure("done did not appear in the control word");
	endtask

	task automatic set_aw(input int b, input logic on);
		aw_valid[b] = on;
		aw_ready[b] = on;
	endtask

	task automatic set_w(input int b, input logic on);
		w_valid[b] = on;
		w_ready[b] = on;
	endtask

	// one write on a bank with address and data together or apart in either order
	task automatic issue_write(input int b);
		logic [31:0] r;
		random_bits(3, r);
		if (r[0]) begin
			set_aw(b, 1'b1);
			set_w(b, 1'b1);
			step_cycle();
		end else begin
			if (r[1])
				set_aw(b, 1'b1);
			else
				set_w(b, 1'b1);
			step_cycle();
			set_aw(b, 1'b0);
			set_w(b, 1'b0);
			repeat (r[2]) step_cycle();
			if (r[1])
				set_w(b, 1'b1);
			else
				set_aw(b, 1'b1);
			step_cycle();
		end
		set_aw(b, 1'b0);
		set_w(b, 1'b0);
		accepted++;
		acks_left[b]++;
	endtask

	task automatic ack_writes();
		logic [31:0] r;
		for (int b = 0; b < NUM_BANKS; b++) begin
			while (acks_left[b] > 0) begin
				random_bits(2, r);
				repeat (r[1:0]) step_cycle();
				b_valid[b] = 1'b1;
				b_ready[b] = 1'b1;
				step_cycle();
				b_valid[b] = 1'b0;
				b_ready[b] = 1'b0;
				acked++;
				acks_left[b]--;
			end
		end
	endtask

	// relocation is combinational, so both channels are compared every cycle
	always @(negedge clk) begin
		if (!reset) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (mem_aw_addr[b] !== relocated(core_aw_addr[b]))
					report_mismatch($sformatf("mem_aw_addr[%0d]", b), mem_aw_addr[b],
						relocated(core_aw_addr[b]));
				if (mem_ar_addr[b] !== relocated(core_ar_addr[b]))
					report_mismatch($sformatf("mem_ar_addr[%0d]", b), mem_ar_addr[b],
						relocated(core_ar_addr[b]));
			end
		end
	end

	initial begin
		ctrl_data_t  word;
		logic [31:0] r;
		logic [31:0] d;
		int          cycles;
		int          start_errors;
		lfsr = 32'h3bd6;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		accepted = 0;
		acked = 0;
		foreach (acks_left[b])
			acks_left[b] = 0;
		reset = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		core_busy = 1'b0;
		core_aw_addr = '0;
		core_ar_addr = '0;
		aw_valid = '0;
		aw_ready = '0;
		w_valid = '0;
		w_ready = '0;
		b_valid = '0;
		b_ready = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		start_errors = errors;
		if (interrupt !== 1'b0)
			report_mismatch("interrupt", interrupt, 0);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		if (dcr_wr_valid !== 1'b0 || reg_rvalid !== 1'b0)
			report_failure("dcr_wr_valid or reg_rvalid high after reset");
		reg_read(REG_CTRL, word);
		if (word !== status_word(1'b1, 1'b0))
			report_mismatch("reg_rdata", word, status_word(1'b1, 1'b0));
		finish_test("reset state", start_errors);

		start_errors = errors;
		for (int i = 0; i < DCR_WRITES; i++) begin
			random_bits(12, r);
			random_bits(32, d);
			reg_write(REG_DCR_ADDR, r);
			if (dcr_wr_valid !== 1'b0)
				report_failure("dcr_wr_valid raised by a DCR address write");
			reg_write(REG_DCR_DATA, d);
			if (dcr_wr_valid !== 1'b1)
				report_failure("dcr_wr_valid missing one cycle after a DCR data write");
			if (dcr_wr_addr !== dcr_addr_t'(r))
				report_mismatch("dcr_wr_addr", dcr_wr_addr, r);
			if (dcr_wr_data !== d)
				report_mismatch("dcr_wr_data", dcr_wr_data, d);
			step_cycle();
			if (dcr_wr_valid !== 1'b0)
				report_failure("dcr_wr_valid stayed high for more than one cycle");
		end
		finish_test("DCR forwarding", start_errors);

		start_errors = errors;
		reg_write(REG_GIE, 32'h1);
		reg_write(REG_IER, 32'h1);
		reg_write(REG_CTRL, 32'h1 << CTRL_START_BIT);
		wait_core_release(cycles);
		if (cycles != RESET_DELAY + 1)
			report_mismatch("core_reset release cycle", cycles, RESET_DELAY + 1);
		random_bits(5, r);
		core_busy = 1'b1;
		repeat (r[4:0] + 1) step_cycle();
		core_busy = 1'b0;
		wait_done(word);
		if (word !== status_word(1'b0, 1'b1))
			report_mismatch("reg_rdata", word, status_word(1'b0, 1'b1));
		if (interrupt !== 1'b1)
			report_mismatch("interrupt", interrupt, 1);
		reg_read(REG_CTRL, word);
		if (word !== status_word(1'b1, 1'b0))
			report_mismatch("reg_rdata", word, status_word(1'b1, 1'b0));
		reg_write(REG_ISR, 32'h1);
		if (interrupt !== 1'b0)
			report_mismatch("interrupt", interrupt, 0);
		finish_test("full run", start_errors);

		// busy falls with every write accepted and none acknowledged yet
		start_errors = errors;
		reg_write(REG_CTRL, 32'h1 << CTRL_START_BIT);
		wait_core_release(cycles);
		core_busy = 1'b1;
		for (int i = 0; i < BANK_WRITES; i++) begin
			for (int b = 0; b < NUM_BANKS; b++)
				issue_write(b);
		end
		core_busy = 1'b0;
		fork
			ack_writes();
			wait_done(word);
		join
		if (interrupt !== 1'b1)
			report_mismatch("interrupt", interrupt, 1);
		if (word !== status_word(1'b0, 1'b1))
			report_mismatch("reg_rdata", word, status_word(1'b0, 1'b1));
		reg_write(REG_ISR, 32'h1);
		if (interrupt !== 1'b0)
			report_mismatch("interrupt", interrupt, 0);
		finish_test("write drain", start_errors);

		start_errors = errors;
		for (int i = 0; i < ADDR_SAMPLES; i++) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				random_bits(32, r);
				core_aw_addr[b] = r;
				random_bits(32, r);
				core_ar_addr[b] = r;
			end
			step_cycle();
		end
		finish_test("address relocation", start_errors);

		start_errors = errors;
		reg_write(REG_CTRL, 32'h1 << CTRL_START_BIT);
		wait_core_release(cycles);
		core_busy = 1'b1;
		repeat (4) step_cycle();
		reg_read(REG_CTRL, word);
		if (word !== status_word(1'b0, 1'b0))
			report_mismatch("reg_rdata", word, status_word(1'b0, 1'b0));
		reg_write(REG_CTRL, 32'h1 << CTRL_SOFT_RESET_BIT);
		step_cycle();
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		core_busy = 1'b0;
		reg_read(REG_CTRL, word);
		if (word !== status_word(1'b1, 1'b0))
			report_mismatch("reg_rdata", word, status_word(1'b1, 1'b0));
		if (interrupt !== 1'b0)
			report_mismatch("interrupt", interrupt, 0);
		finish_test("soft reset", start_errors);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* list.f */
rtl/afu_cfg_pkg.sv
rtl/afu_mem_pkg.sv
rtl/kernel_ctrl_if.sv
rtl/host_ctrl_regs.sv
rtl/kernel_run_fsm.sv
rtl/mem_bank_port.sv
rtl/write_drain_counter.sv
rtl/afu_top.sv
tests/afu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f list.f \
		--top-module afu_tb -o afu_sim \
	&& ./obj_dir/afu_sim | tee /dev/stderr | grep "RESULT: PASS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
